//--- include/soc_defines.svh
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// lowest word address bit of a 256 byte device page
`define SOC_PAGE_LSB 6

// upper word address bits of the device pages
`define SOC_PAGE_TIMER 24'hFFFFFD // FFFFFD00 - FFFFFDFF
`define SOC_PAGE_PRNG  24'hFFFFFE // FFFFFE00 - FFFFFEFF

// block ram word address width, 1024 words
`define SOC_RAM_ADDR_BITS 10

// internal reset length after the button is released
`define SOC_RESET_CYCLES 16

// prng state after reset or a zero write
`define SOC_PRNG_SEED 32'h1234_5678

`endif

//--- verilog/soc_pkg.sv
package soc_pkg;

    // one bus data word
    typedef logic [31:0] word_t;

    // word address, the two byte offset bits are implied
    typedef logic [29:0] wb_adr_t;

    // byte lane select, bit n covers bits 8n+7:8n
    typedef logic [3:0] wb_sel_t;

    // owner of the response that comes back next cycle
    typedef enum logic [1:0] {
        SLAVE_RAM   = 2'd0, // default region
        SLAVE_TIMER = 2'd1, // page FFFFFDxx
        SLAVE_PRNG  = 2'd2  // page FFFFFExx
    } slave_e;

endpackage

//--- verilog/wb_if.sv
interface wb_if;

    soc_pkg::wb_adr_t adr;   // full word address, slaves pick low bits
    soc_pkg::word_t   dat_w;
    soc_pkg::wb_sel_t sel;
    logic             we;
    logic             stb;
    soc_pkg::word_t   dat_r; // valid with ack on reads
    logic             ack;   // one cycle after stb

    modport master (
        output adr,
        output dat_w,
        output sel,
        output we,
        output stb,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  adr,
        input  dat_w,
        input  sel,
        input  we,
        input  stb,
        output dat_r,
        output ack
    );

endinterface

//--- verilog/reset_gen.sv
`include "soc_defines.svh"

module reset_gen (
    input  logic clk,
    input  logic reset_button,
    output logic soc_reset_o
);

    localparam int CNT_W = $clog2(`SOC_RESET_CYCLES + 1);

    logic [CNT_W-1:0] cnt; // cycles left before release

    // block ram needs some time to settle after power up,
    // so the internal reset outlasts the button by a fixed count
    always_ff @(posedge clk) begin
        if (!reset_button) begin
            cnt         <= CNT_W'(`SOC_RESET_CYCLES);
            soc_reset_o <= 1'b1;
        end else if (cnt != '0) begin
            cnt         <= cnt - 1'b1;
            soc_reset_o <= 1'b1;
        end else begin
            soc_reset_o <= 1'b0;
        end
    end

endmodule

//--- verilog/wb_decoder.sv
`include "soc_defines.svh"

module wb_decoder (
    input  logic             clk,
    input  logic             soc_reset_i,
    input  soc_pkg::wb_adr_t wb_adr_i,
    input  soc_pkg::word_t   wb_dat_i,
    input  soc_pkg::wb_sel_t wb_sel_i,
    input  logic             wb_we_i,
    input  logic             wb_stb_i,
    output soc_pkg::word_t   wb_dat_o,
    output logic             wb_ack_o,
    output logic             wb_stall_o,
    wb_if.master             ram,
    wb_if.master             timer,
    wb_if.master             prng
);

    soc_pkg::slave_e sel_d; // slave addressed this cycle
    soc_pkg::slave_e sel_q; // slave that answers this cycle
    logic            req;   // accepted request

    // nothing is accepted while the internal reset runs
    assign req        = wb_stb_i && !soc_reset_i;
    assign wb_stall_o = soc_reset_i;

    always_comb begin
        if (wb_adr_i[29:`SOC_PAGE_LSB] == `SOC_PAGE_TIMER) begin
            sel_d = soc_pkg::SLAVE_TIMER;
        end else if (wb_adr_i[29:`SOC_PAGE_LSB] == `SOC_PAGE_PRNG) begin
            sel_d = soc_pkg::SLAVE_PRNG;
        end else begin
            sel_d = soc_pkg::SLAVE_RAM; // everything else is ram
        end
    end

    // request fields go to every slave, only stb is steered
    assign ram.adr     = wb_adr_i;
    assign ram.dat_w   = wb_dat_i;
    assign ram.sel     = wb_sel_i;
    assign ram.we      = wb_we_i;
    assign ram.stb     = req && (sel_d == soc_pkg::SLAVE_RAM);

    assign timer.adr   = wb_adr_i;
    assign timer.dat_w = wb_dat_i;
    assign timer.sel   = wb_sel_i;
    assign timer.we    = wb_we_i;
    assign timer.stb   = req && (sel_d == soc_pkg::SLAVE_TIMER);

    assign prng.adr    = wb_adr_i;
    assign prng.dat_w  = wb_dat_i;
    assign prng.sel    = wb_sel_i;
    assign prng.we     = wb_we_i;
    assign prng.stb    = req && (sel_d == soc_pkg::SLAVE_PRNG);

    always_ff @(posedge clk) begin
        if (soc_reset_i) begin
            sel_q <= soc_pkg::SLAVE_RAM;
        end else if (req) begin
            sel_q <= sel_d;
        end
    end

    // slaves answer in one fixed cycle, so the last owner is enough
    always_comb begin
        unique case (sel_q)
            soc_pkg::SLAVE_TIMER: begin
                wb_dat_o = timer.dat_r;
                wb_ack_o = timer.ack;
            end
            soc_pkg::SLAVE_PRNG: begin
                wb_dat_o = prng.dat_r;
                wb_ack_o = prng.ack;
            end
            default: begin
                wb_dat_o = ram.dat_r;
                wb_ack_o = ram.ack;
            end
        endcase
    end

endmodule

//--- verilog/bram_wb32.sv
`include "soc_defines.svh"

module bram_wb32 #(
    parameter int ADDR_BITS = `SOC_RAM_ADDR_BITS
) (
    input logic clk,
    wb_if.slave bus
);

    localparam int DEPTH = 2 ** ADDR_BITS;

    logic [ADDR_BITS-1:0] idx;
    soc_pkg::word_t       mem [DEPTH];

    // higher address bits alias onto the array
    assign idx = bus.adr[ADDR_BITS-1:0];

    // byte lane writes
    always_ff @(posedge clk) begin
        if (bus.stb && bus.we) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.sel[i]) begin
                    mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
                end
            end
        end
    end

    // registered read, old contents on a write cycle
    always_ff @(posedge clk) begin
        if (bus.stb) begin
            bus.dat_r <= mem[idx];
        end
    end

    // stb is held low by the decoder during reset
    always_ff @(posedge clk) begin
        bus.ack <= bus.stb;
    end

endmodule

//--- verilog/timer_wb32.sv
module timer_wb32 (
    input  logic clk,
    input  logic soc_reset_i,
    wb_if.slave  bus,
    output logic irq_o
);

    soc_pkg::word_t counter;
    soc_pkg::word_t compare;
    logic           enable;
    logic           pending;   // sticky until written with bit 1
    logic           wr_cmp;    // word 0 write
    logic           wr_ctrl;   // word 1 write

    assign wr_cmp  = bus.stb && bus.we && !bus.adr[0];
    assign wr_ctrl = bus.stb && bus.we && bus.adr[0];
    assign irq_o   = pending;

    always_ff @(posedge clk) begin
        if (soc_reset_i) begin
            counter <= '0;
            compare <= '0;
            enable  <= 1'b0;
            pending <= 1'b0;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.stb;

            if (wr_cmp) begin
                counter <= '0; // new compare restarts the count
                compare <= bus.dat_w;
            end else if (enable) begin
                counter <= counter + 1'b1;
            end

            if (wr_ctrl) begin
                enable <= bus.dat_w[0];
            end

            // a hit in the same cycle as a clear wins
            if (enable && (counter == compare)) begin
                pending <= 1'b1;
            end else if (wr_ctrl && bus.dat_w[1]) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.stb) begin
            bus.dat_r <= bus.adr[0] ? {30'b0, pending, enable} : counter;
        end
    end

endmodule

//--- verilog/prng_wb32.sv
`include "soc_defines.svh"

module prng_wb32 (
    input logic clk,
    input logic soc_reset_i,
    wb_if.slave bus
);

    soc_pkg::word_t state;
    soc_pkg::word_t merged; // state with the written bytes

    function automatic soc_pkg::word_t xorshift32(input soc_pkg::word_t x);
        soc_pkg::word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always_comb begin
        merged = state;
        for (int i = 0; i < 4; i++) begin
            if (bus.sel[i]) begin
                merged[8*i +: 8] = bus.dat_w[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (soc_reset_i) begin
            state   <= `SOC_PRNG_SEED;
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.stb;
            if (bus.stb && bus.we) begin
                // zero is a fixed point of xorshift, never keep it
                state <= (merged == '0) ? `SOC_PRNG_SEED : merged;
            end else if (bus.stb) begin
                state <= xorshift32(state); // advance on read
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.stb) begin
            bus.dat_r <= state;
        end
    end

endmodule

//--- verilog/soc_top.sv
`include "soc_defines.svh"

module soc_top (
    input  logic             clk,
    input  logic             reset_button,
    input  soc_pkg::wb_adr_t wb_adr_i,
    input  soc_pkg::word_t   wb_dat_i,
    input  soc_pkg::wb_sel_t wb_sel_i,
    input  logic             wb_we_i,
    input  logic             wb_stb_i,
    output soc_pkg::word_t   wb_dat_o,
    output logic             wb_ack_o,
    output logic             wb_stall_o,
    output logic             timer_irq_o
);

    logic soc_reset; // stretched, active high

    // one slave port per device
    wb_if ram_bus ();
    wb_if timer_bus ();
    wb_if prng_bus ();

    reset_gen i_reset_gen (
        .clk          (clk),
        .reset_button (reset_button),
        .soc_reset_o  (soc_reset)
    );

    wb_decoder i_wb_decoder (
        .clk         (clk),
        .soc_reset_i (soc_reset),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_sel_i    (wb_sel_i),
        .wb_we_i     (wb_we_i),
        .wb_stb_i    (wb_stb_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .wb_stall_o  (wb_stall_o),
        .ram         (ram_bus.master),
        .timer       (timer_bus.master),
        .prng        (prng_bus.master)
    );

    // default region, 4 KB
    bram_wb32 #(
        .ADDR_BITS (`SOC_RAM_ADDR_BITS)
    ) i_bram_wb32 (
        .clk (clk),
        .bus (ram_bus.slave)
    );

    timer_wb32 i_timer_wb32 (
        .clk         (clk),
        .soc_reset_i (soc_reset),
        .bus         (timer_bus.slave),
        .irq_o       (timer_irq_o)
    );

    prng_wb32 i_prng_wb32 (
        .clk         (clk),
        .soc_reset_i (soc_reset),
        .bus         (prng_bus.slave)
    );

endmodule

//--- tb/soc_top_chk.sv
module soc_top_chk (
    input logic clk,
    input logic reset_button,
    input logic wb_stb_i,
    input logic wb_stall_o,
    input logic wb_ack_o,
    input logic timer_irq_o
);

    int fail_count = 0; // read by the testbench verdict

    // one ack for every accepted strobe, one cycle later
    ack_follows_req: assert property (@(posedge clk) disable iff (!reset_button)
        wb_ack_o == $past(wb_stb_i && !wb_stall_o)
    ) else begin
        $error("ack does not follow the accepted strobe");
        fail_count++;
    end

    stall_in_reset: assert property (@(posedge clk)
        !reset_button |=> wb_stall_o
    ) else begin
        $error("stall low while the reset button is pressed");
        fail_count++;
    end

    // nothing comes back while the stretched reset runs
    quiet_in_stall: assert property (@(posedge clk) disable iff (!reset_button)
        wb_stall_o |-> (!wb_ack_o && !timer_irq_o)
    ) else begin
        $error("ack or irq during stall");
        fail_count++;
    end

endmodule

bind soc_top soc_top_chk i_soc_top_chk (.*);

//--- tb/soc_top_tb.sv
`include "soc_defines.svh"

module soc_top_tb;

    localparam int RAM_WORDS = 1 << `SOC_RAM_ADDR_BITS;
    localparam int RAM_OPS   = 300;
    localparam int PRNG_OPS  = 80;
    localparam int MIX_OPS   = 200;
    localparam int TOTAL_LEN = (8 + `SOC_RESET_CYCLES + 2) + (RAM_WORDS + RAM_OPS * 4)
                             + PRNG_OPS * 2 + 100 + (MIX_OPS + 4);
    localparam int CYCLE_LIMIT = TOTAL_LEN + TOTAL_LEN / 5;

    logic             clk = 1'b0;
    logic             reset_button;
    soc_pkg::wb_adr_t wb_adr_i;
    soc_pkg::word_t   wb_dat_i;
    soc_pkg::wb_sel_t wb_sel_i;
    logic             wb_we_i;
    logic             wb_stb_i;
    soc_pkg::word_t   wb_dat_o;
    logic             wb_ack_o;
    logic             wb_stall_o;
    logic             timer_irq_o;

    // reference model state
    soc_pkg::word_t   ram_m [RAM_WORDS];
    soc_pkg::word_t   prng_m = `SOC_PRNG_SEED;
    soc_pkg::word_t   t_cnt = '0;
    soc_pkg::word_t   t_cmp = '0;
    logic             t_en = 1'b0;
    logic             t_pend = 1'b0;

    // request seen on the bus, accepted at the next edge
    logic             acc_valid = 1'b0;
    soc_pkg::wb_adr_t acc_adr = '0;
    soc_pkg::word_t   acc_dat = '0;
    soc_pkg::wb_sel_t acc_sel = '0;
    logic             acc_we = 1'b0;
    soc_pkg::word_t   exp_q [$];
    bit               rd_q [$];
    logic             mon_on = 1'b0;
    int               cycle_cnt = 0;
    soc_pkg::word_t   cmp;

    soc_top i_soc_top (.*);

    always #50 clk = ~clk;

    function automatic soc_pkg::slave_e page_of(input soc_pkg::wb_adr_t a);
        if (a[29:`SOC_PAGE_LSB] == `SOC_PAGE_TIMER) begin
            return soc_pkg::SLAVE_TIMER;
        end else if (a[29:`SOC_PAGE_LSB] == `SOC_PAGE_PRNG) begin
            return soc_pkg::SLAVE_PRNG;
        end
        return soc_pkg::SLAVE_RAM;
    endfunction

    function automatic soc_pkg::wb_adr_t random_ram_adr();
        soc_pkg::wb_adr_t a;
        a = soc_pkg::wb_adr_t'($urandom);
        while (page_of(a) != soc_pkg::SLAVE_RAM) begin
            a = soc_pkg::wb_adr_t'($urandom);
        end
        return a;
    endfunction

    function automatic soc_pkg::wb_adr_t timer_adr(input logic w);
        return {`SOC_PAGE_TIMER, 5'($urandom), w}; // only bit 0 picks the register
    endfunction

    function automatic soc_pkg::wb_adr_t prng_adr();
        return {`SOC_PAGE_PRNG, 6'($urandom)};
    endfunction

    function automatic soc_pkg::word_t merge_bytes(input soc_pkg::word_t old,
            input soc_pkg::word_t dat, input soc_pkg::wb_sel_t sel);
        soc_pkg::word_t r;
        r = old;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                r[8*i +: 8] = dat[8*i +: 8];
            end
        end
        return r;
    endfunction

    function automatic soc_pkg::word_t next_prng(input soc_pkg::word_t s);
        soc_pkg::word_t t;
        t = s ^ (s << 13);
        t = t ^ (t >> 17);
        return t ^ (t << 5);
    endfunction

    task automatic check_word(input soc_pkg::word_t got, input soc_pkg::word_t exp,
            input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "word check failed");
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "bit check failed");
        end
    endtask

    task automatic drive_req(input soc_pkg::wb_adr_t adr, input soc_pkg::word_t dat,
            input soc_pkg::wb_sel_t sel, input logic we);
        @(posedge clk);
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        wb_sel_i <= sel;
        wb_we_i  <= we;
        wb_stb_i <= 1'b1;
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            wb_stb_i <= 1'b0;
        end
    endtask

    // model effect of the clock edge that just passed
    task automatic apply_edge();
        soc_pkg::slave_e pg;
        logic            hit;
        logic            wr_cmp;
        logic            wr_ctrl;
        soc_pkg::word_t  m;
        pg      = page_of(acc_adr);
        hit     = t_en && (t_cnt == t_cmp);
        wr_cmp  = acc_valid && acc_we && (pg == soc_pkg::SLAVE_TIMER) && !acc_adr[0];
        wr_ctrl = acc_valid && acc_we && (pg == soc_pkg::SLAVE_TIMER) && acc_adr[0];
        if (wr_cmp) begin
            t_cnt = '0;
            t_cmp = acc_dat;
        end else if (t_en) begin
            t_cnt = t_cnt + 1;
        end
        if (wr_ctrl) begin
            t_en = acc_dat[0];
        end
        if (hit) begin
            t_pend = 1'b1;
        end else if (wr_ctrl && acc_dat[1]) begin
            t_pend = 1'b0;
        end
        if (acc_valid && acc_we && pg == soc_pkg::SLAVE_RAM) begin
            ram_m[acc_adr % RAM_WORDS] = merge_bytes(ram_m[acc_adr % RAM_WORDS], acc_dat, acc_sel);
        end
        if (acc_valid && pg == soc_pkg::SLAVE_PRNG) begin
            m      = merge_bytes(prng_m, acc_dat, acc_sel);
            prng_m = acc_we ? ((m == '0) ? `SOC_PRNG_SEED : m) : next_prng(prng_m);
        end
    endtask

    always @(negedge clk) begin
        if (mon_on) begin
            apply_edge();
            check_bit(wb_ack_o, acc_valid, "ack");
            if (wb_ack_o && rd_q.pop_front()) begin
                check_word(wb_dat_o, exp_q.pop_front(), $sformatf("read of %h", acc_adr));
            end else if (wb_ack_o) begin
                void'(exp_q.pop_front()); // write, data is don't care
            end
            check_bit(timer_irq_o, t_pend, "timer irq");
            acc_valid = wb_stb_i && !wb_stall_o;
            acc_adr   = wb_adr_i;
            acc_dat   = wb_dat_i;
            acc_sel   = wb_sel_i;
            acc_we    = wb_we_i;
            if (acc_valid) begin
                rd_q.push_back(!wb_we_i);
                case (page_of(wb_adr_i))
                    soc_pkg::SLAVE_TIMER: begin
                        if (wb_adr_i[0]) begin
                            exp_q.push_back({30'b0, t_pend, t_en});
                        end else begin
                            exp_q.push_back(t_cnt);
                        end
                    end
                    soc_pkg::SLAVE_PRNG:  exp_q.push_back(prng_m);
                    default:              exp_q.push_back(ram_m[wb_adr_i % RAM_WORDS]);
                endcase
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout, no verdict after %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(41));
        reset_button = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        wb_sel_i     = 4'hF;
        wb_we_i      = 1'b0;
        wb_stb_i     = 1'b0;
        repeat (7) begin
            @(posedge clk);
            @(negedge clk);
            check_bit(wb_stall_o, 1'b1, "stall with button pressed");
        end
        @(posedge clk);
        reset_button <= 1'b1;
        mon_on       <= 1'b1;
        wb_stb_i     <= 1'b1; // offered all through the stretch
        wb_we_i      <= 1'b1;
        for (int k = 0; k < `SOC_RESET_CYCLES; k++) begin
            @(posedge clk);
            wb_adr_i <= random_ram_adr();
            wb_dat_i <= $urandom;
            @(negedge clk);
            check_bit(wb_stall_o, 1'b1, "stall during reset stretch");
        end
        @(posedge clk);
        wb_stb_i <= 1'b0;
        @(negedge clk);
        check_bit(wb_stall_o, 1'b0, "stall after reset stretch");

        for (int i = 0; i < RAM_WORDS; i++) begin
            drive_req(soc_pkg::wb_adr_t'(i), (soc_pkg::word_t'(i) * 32'h9E37_79B1) ^ 32'h5A5A_0F0F,
                4'hF, 1'b1);
        end
        repeat (RAM_OPS) begin
            drive_req(random_ram_adr(), $urandom, 4'($urandom), 1'($urandom));
            if ($urandom % 2) drive_idle($urandom % 3 + 1);
        end

        for (int i = 0; i < PRNG_OPS; i++) begin
            if (i == PRNG_OPS / 2) begin
                drive_req(prng_adr(), '0, 4'hF, 1'b1); // zero falls back to the seed
            end else if ($urandom % 4 == 0) begin
                drive_req(prng_adr(), $urandom, 4'($urandom), 1'b1);
            end else begin
                drive_req(prng_adr(), '0, 4'h0, 1'b0);
            end
            if ($urandom % 3 == 0) drive_idle(1);
        end

        cmp = 5 + $urandom % 36;
        drive_req(timer_adr(1'b0), cmp, 4'hF, 1'b1);
        drive_req(timer_adr(1'b1), 32'h1, 4'hF, 1'b1);
        drive_idle(cmp / 2);
        drive_req(timer_adr(1'b0), '0, 4'h0, 1'b0); // counter read mid way
        drive_idle(cmp + 4);
        @(negedge clk);
        check_bit(timer_irq_o, 1'b1, "timer irq after compare");
        drive_req(timer_adr(1'b1), 32'h3, 4'hF, 1'b1); // keep enable and clear
        drive_idle(2);
        @(negedge clk);
        check_bit(timer_irq_o, 1'b0, "timer irq after clear");

        repeat (MIX_OPS) begin
            case ($urandom % 3)
                0:       drive_req(random_ram_adr(), $urandom, 4'($urandom), 1'($urandom));
                1:       drive_req(timer_adr(1'($urandom)), '0, 4'h0, 1'b0);
                default: drive_req(prng_adr(), $urandom, 4'($urandom), 1'($urandom));
            endcase
        end
        drive_idle(3);
        @(negedge clk);

        if (i_soc_top.i_soc_top_chk.fail_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("%0d assertion failures", i_soc_top.i_soc_top_chk.fail_count);
            $display("Simulation finished: FAIL");
            $fatal(1, "run failed");
        end
    end

endmodule

//--- soc_top.f
+incdir+include
verilog/soc_pkg.sv
verilog/wb_if.sv
verilog/reset_gen.sv
verilog/wb_decoder.sv
verilog/bram_wb32.sv
verilog/timer_wb32.sv
verilog/prng_wb32.sv
verilog/soc_top.sv
tb/soc_top_chk.sv
tb/soc_top_tb.sv

//--- Bender.yml
package:
  name: soc_top

export_include_dirs:
  - include

sources:
  - files:
      - verilog/soc_pkg.sv
      - verilog/wb_if.sv
      - verilog/reset_gen.sv
      - verilog/wb_decoder.sv
      - verilog/bram_wb32.sv
      - verilog/timer_wb32.sv
      - verilog/prng_wb32.sv
      - verilog/soc_top.sv
  - target: test
    files:
      - tb/soc_top_chk.sv
      - tb/soc_top_tb.sv
